/* hdl/gba_video_pkg.sv */
// Single clock domain; 240x160 frame, one pixel per CE_DIV clocks, 15-bit colour in, 24-bit out
package gba_video_pkg;

	// ========================================================================
	// Display geometry
	// ========================================================================
	localparam int COORD_W        = 9;                   // Raster x and y counter width
	localparam int H_ACTIVE       = 240;                 // Visible pixels per line
	localparam int V_ACTIVE       = 160;                 // Visible lines
	localparam int H_LAST         = 398;                 // 399 pixels per line
	localparam int HS_START       = 293;
	localparam int HS_WIDTH       = 32;
	localparam int VS_LINE_ON     = 1;                   // Line whose hsync raises vsync
	localparam int VS_LINE_OFF    = 4;
	localparam int V_START        = 62;                  // First visible line
	localparam int FB_DEPTH       = H_ACTIVE * V_ACTIVE; // 38400 words
	localparam int CE_DIV         = 8;                   // System clocks per pixel
	localparam int FSTART_STRETCH = 8;                   // Frame-start level hold, in clocks

	// ========================================================================
	// Pixel, sync and write-port types
	// ========================================================================
	typedef logic [15:0] fb_addr_t;

	typedef struct packed {
		logic [4:0] r;  // Red in the top bits
		logic [4:0] g;
		logic [4:0] b;
	} pixel15_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb24_t;

	typedef struct packed {
		logic     we;   // One-cycle strobe, no handshake
		fb_addr_t addr;
		pixel15_t data;
	} fb_write_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hbl;
		logic vbl;
	} sync_t;

	typedef logic [1:0] desat_level_t;  // 0 = off, 3 = strongest

	// State of the sync bits out of reset: vertical blank only
	localparam sync_t SYNC_IDLE = '{hs: 1'b0, vs: 1'b0, hbl: 1'b0, vbl: 1'b1};

endpackage

/* hdl/frame_buffer.sv */
// Writes outside 0..FB_DEPTH-1 are dropped; read data lags the address by one clock
module frame_buffer (
	input  logic                     clk_sys,
	input  gba_video_pkg::fb_write_t wr,
	input  gba_video_pkg::fb_addr_t  rd_addr,
	output gba_video_pkg::pixel15_t  rd_data
);

	// ========================================================================
	// Storage
	// ========================================================================
	// One word per visible pixel, raster order, no initial contents
	gba_video_pkg::pixel15_t mem [gba_video_pkg::FB_DEPTH];

	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr.we && (wr.addr < gba_video_pkg::FB_DEPTH);
	assign rd_ok = rd_addr < gba_video_pkg::FB_DEPTH;

	// ========================================================================
	// Write port from the core
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (wr_ok) begin
			mem[wr.addr] <= wr.data;  // Visible on the next read cycle
		end
	end

	// ========================================================================
	// Scan-out read port
	// ========================================================================
	// The address can step one past the last word at the end of the last
	// visible line; the output just holds in that case
	always_ff @(posedge clk_sys) begin
		if (rd_ok) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* hdl/video_timing.sv */
// 399 x up to 512 raster, pixel tick every CE_DIV clocks; realigns only if frame start hits vblank
module video_timing (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gba_video_pkg::fb_write_t fb_wr,
	output gba_video_pkg::fb_addr_t  rd_addr,
	input  gba_video_pkg::pixel15_t  rd_data,
	output logic                     tick,
	output gba_video_pkg::pixel15_t  pixel,
	output gba_video_pkg::sync_t     raw_sync
);

	logic [$clog2(gba_video_pkg::CE_DIV)-1:0] div;
	logic [gba_video_pkg::COORD_W-1:0]        x;
	logic [gba_video_pkg::COORD_W-1:0]        y;
	logic [gba_video_pkg::FSTART_STRETCH-1:0] fstart_sr;
	logic                                     fstart;    // Stretched frame-start level
	logic                                     fstart_d;
	logic                                     realign;
	gba_video_pkg::sync_t                     sync_next;

	// ========================================================================
	// Pixel enable
	// ========================================================================
	assign tick = (div == '0);  // First clock after reset, then every eighth

	// ========================================================================
	// Sync and blank for the current raster position
	// ========================================================================
	always_comb begin
		sync_next = raw_sync;

		if (x == gba_video_pkg::H_ACTIVE) sync_next.hbl = 1'b1;
		if (x == '0)                      sync_next.hbl = 1'b0;

		if (x == gba_video_pkg::HS_START) begin
			sync_next.hs = 1'b1;
			if (y == gba_video_pkg::VS_LINE_ON)  sync_next.vs = 1'b1;
			if (y == gba_video_pkg::VS_LINE_OFF) sync_next.vs = 1'b0;
		end
		if (x == gba_video_pkg::HS_START + gba_video_pkg::HS_WIDTH) begin
			sync_next.hs = 1'b0;
		end

		if (y == gba_video_pkg::V_START) sync_next.vbl = 1'b0;
		if (y >= gba_video_pkg::V_START + gba_video_pkg::V_ACTIVE) begin
			sync_next.vbl = 1'b1;
		end
	end

	// Frame start from the core, honoured only inside vertical blank
	assign realign = fstart & ~fstart_d & raw_sync.vbl;

	// ========================================================================
	// Raster counters, read address, frame-start stretcher
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div       <= '0;
			x         <= '0;
			y         <= '0;
			rd_addr   <= '0;
			raw_sync  <= gba_video_pkg::SYNC_IDLE;
			fstart_sr <= '0;
			fstart    <= 1'b0;
			fstart_d  <= 1'b0;
		end else begin
			div <= div + 1'b1;

			// Write to word 0 marks a new frame
			fstart_sr <= fstart_sr << 1;
			if (fb_wr.we && fb_wr.addr == '0) begin
				fstart_sr <= {{(gba_video_pkg::FSTART_STRETCH - 1){1'b0}}, 1'b1};
			end
			fstart   <= |fstart_sr;
			fstart_d <= fstart;

			if (tick) begin
				raw_sync <= sync_next;

				if (x == gba_video_pkg::H_LAST) begin
					x <= '0;
					if (y != '1) y <= y + 1'b1;  // Saturates until realigned
				end else begin
					x <= x + 1'b1;
				end

				// Memory read lags one tick, so the address runs one word ahead
				if (sync_next.vbl) begin
					rd_addr <= '0;
				end else if (!sync_next.hbl) begin
					rd_addr <= rd_addr + 1'b1;
				end
			end

			if (realign) begin  // Overrides the tick update
				x           <= '0;
				y           <= '0;
				raw_sync.hs <= 1'b0;
				raw_sync.vs <= 1'b0;
			end
		end
	end

	// Pixel sample, taken on the same edge as the sync update
	always_ff @(posedge clk_sys) begin
		if (tick) begin
			pixel <= rd_data;
		end
	end

endmodule

/* hdl/desaturate_filter.sv */
// Level is sampled every tick with no hold-off; output colour is undefined until a written word shows
module desaturate_filter (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        tick,
	input  gba_video_pkg::pixel15_t     pixel,
	input  gba_video_pkg::sync_t        raw_sync,
	input  gba_video_pkg::desat_level_t level,
	output logic                        ce_pix,
	output gba_video_pkg::rgb24_t       rgb,
	output gba_video_pkg::sync_t        sync
);

	gba_video_pkg::rgb24_t wide;
	gba_video_pkg::rgb24_t rgb_next;
	logic [7:0]            luma;

	// Mix one channel with luma; all sums wrap to 8 bits
	function automatic logic [7:0] mix_channel(
		input logic [7:0]                  c,
		input logic [7:0]                  lum,
		input gba_video_pkg::desat_level_t lvl
	);
		logic [7:0] res;
		case (lvl)
			2'd0:    res = c;
			2'd1:    res = c[7:1] + c[7:2] + lum[7:2];      // 3/4 colour, 1/4 luma
			2'd2:    res = c[7:1] + lum[7:1];               // Half and half
			default: res = lum[7:1] + lum[7:2] + c[7:2];    // 3/4 luma
		endcase
		return res;
	endfunction

	// ========================================================================
	// Widening and luma
	// ========================================================================
	// Top bits repeated into the low end so full scale maps to 255
	assign wide.r = {pixel.r, pixel.r[4:2]};
	assign wide.g = {pixel.g, pixel.g[4:2]};
	assign wide.b = {pixel.b, pixel.b[4:2]};

	assign luma = wide.r[7:2] + wide.g[7:1] + wide.g[7:3] + wide.b[7:3];

	assign rgb_next.r = mix_channel(wide.r, luma, level);
	assign rgb_next.g = mix_channel(wide.g, luma, level);
	assign rgb_next.b = mix_channel(wide.b, luma, level);

	// ========================================================================
	// Output register
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce_pix <= 1'b0;
			sync   <= gba_video_pkg::SYNC_IDLE;
		end else begin
			ce_pix <= tick;
			if (tick) begin
				sync <= raw_sync;  // Same edge as the colour below
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tick) begin
			rgb <= rgb_next;
		end
	end

endmodule

/* hdl/gba_video_out.sv */
// One clock for core writes and scan-out; rgb and sync are only meaningful while ce_pix is high
module gba_video_out (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gba_video_pkg::fb_write_t    fb_wr,
	input  gba_video_pkg::desat_level_t desat,
	output logic                        ce_pix,
	output gba_video_pkg::sync_t        sync,
	output gba_video_pkg::rgb24_t       rgb
);

	gba_video_pkg::fb_addr_t  rd_addr;
	gba_video_pkg::pixel15_t  rd_data;
	gba_video_pkg::pixel15_t  pixel;
	gba_video_pkg::sync_t     raw_sync;
	logic                     tick;

	// ========================================================================
	// Frame buffer, raster timing, colour filter
	// ========================================================================
	frame_buffer u_fb (
		.clk_sys (clk_sys),
		.wr      (fb_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	video_timing u_timing (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.fb_wr    (fb_wr),     // Watched for the frame-start word
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.tick     (tick),
		.pixel    (pixel),
		.raw_sync (raw_sync)
	);

	desaturate_filter u_filter (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.tick     (tick),
		.pixel    (pixel),
		.raw_sync (raw_sync),
		.level    (desat),
		.ce_pix   (ce_pix),
		.rgb      (rgb),
		.sync     (sync)
	);

endmodule

/* sim/tb_gba_video_out.sv */
// Several frames of up to 1.6M clocks each; the frame buffer starts with no known contents
module tb_gba_video_out;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LINE_PIX    = gba_video_pkg::H_LAST + 1;  // 399 pixels per line
	localparam int FRAME_PIX   = 512 * LINE_PIX;             // Longest possible frame
	localparam int PULSE_LIMIT = 2 * gba_video_pkg::CE_DIV;
	localparam int HS_BIT      = 3;                          // Bit positions inside sync_t
	localparam int VS_BIT      = 2;
	localparam int VBL_BIT     = 0;

	logic                        clk_sys;
	logic                        reset;
	gba_video_pkg::fb_write_t    fb_wr;
	gba_video_pkg::desat_level_t desat;
	logic                        ce_pix;
	gba_video_pkg::sync_t        sync;
	gba_video_pkg::rgb24_t       rgb;

	gba_video_pkg::sync_t        cur_sync;  // Last sampled pixel
	gba_video_pkg::rgb24_t       cur_rgb;
	gba_video_pkg::pixel15_t     expected [gba_video_pkg::FB_DEPTH];

	gba_video_out u_dut (
		.clk_sys (clk_sys),
		.reset   (reset),
		.fb_wr   (fb_wr),
		.desat   (desat),
		.ce_pix  (ce_pix),
		.sync    (sync),
		.rgb     (rgb)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Failure reporting and compare tasks
	// ========================================================================
	task automatic stop_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		stop_run();
	endtask

	task automatic check_rgb(input gba_video_pkg::rgb24_t got, input gba_video_pkg::rgb24_t exp,
			input string what);
		if (got !== exp) begin
			$display("Error at %0d ns: %s, rgb %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_sync(input gba_video_pkg::sync_t got, input gba_video_pkg::sync_t exp,
			input string what);
		if (got !== exp) begin
			$display("Error at %0d ns: %s, hs/vs/hbl/vbl %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Error at %0d ns: %s, count %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	// ========================================================================
	// Reference colour model
	// ========================================================================
	function automatic int mix_level(input int x, input int l, input int lvl);
		int res;
		case (lvl)
			0:       res = x;
			1:       res = (x / 2 + x / 4 + l / 4) % 256;
			2:       res = (x / 2 + l / 2) % 256;
			default: res = (l / 2 + l / 4 + x / 4) % 256;
		endcase
		return res;
	endfunction

	function automatic gba_video_pkg::rgb24_t model_colour(input gba_video_pkg::pixel15_t p,
			input int lvl);
		int                    r;
		int                    g;
		int                    b;
		int                    l;
		gba_video_pkg::rgb24_t c;
		r = p.r * 8 + p.r / 4;  // 5 to 8 bits, top bits copied below
		g = p.g * 8 + p.g / 4;
		b = p.b * 8 + p.b / 4;
		l = (r / 4 + g / 2 + g / 8 + b / 8) % 256;
		c.r = 8'(mix_level(r, l, lvl));
		c.g = 8'(mix_level(g, l, lvl));
		c.b = 8'(mix_level(b, l, lvl));
		return c;
	endfunction

	// ========================================================================
	// Pixel sampling and frame-buffer writes
	// ========================================================================
	// Counts falling edges up to and including the next one with ce_pix high
	task automatic wait_pulse(output int gap);
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!ce_pix && gap < PULSE_LIMIT);
		if (!ce_pix) report_timeout("no ce_pix pulse within 16 clocks");
	endtask

	task automatic next_pixel();
		int gap;
		wait_pulse(gap);
		cur_sync = sync;  // Stable between rising edges
		cur_rgb  = rgb;
	endtask

	// Steps pixels until a sync bit reaches a value; n is the number skipped
	task automatic run_until(input int idx, input logic val, input int limit,
			input string what, output int n);
		n = 0;
		while (cur_sync[idx] !== val) begin
			if (n >= limit) report_timeout(what);
			n++;
			next_pixel();
		end
	endtask

	task automatic write_word(input gba_video_pkg::fb_addr_t a, input gba_video_pkg::pixel15_t d);
		@(negedge clk_sys);
		fb_wr = '{we: 1'b1, addr: a, data: d};
		expected[a] = d;
	endtask

	task automatic end_writes();
		@(negedge clk_sys);
		fb_wr = '0;
	endtask

	// Word 0 goes last, so the frame restarts once the buffer is full
	task automatic fill_frame();
		logic [31:0] rnd;
		for (int a = 1; a < gba_video_pkg::FB_DEPTH; a++) begin
			rnd = $urandom();
			write_word(gba_video_pkg::fb_addr_t'(a), rnd[14:0]);
		end
		rnd = $urandom();
		write_word('0, rnd[14:0]);
		end_writes();
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic reset_and_rate();
		gba_video_pkg::sync_t idle;
		int                   gap;
		idle     = '0;
		idle.vbl = 1'b1;
		check_sync(sync, idle, "sync right after reset");
		check_count((ce_pix === 1'b0) ? 0 : 1, 0, "ce_pix right after reset");
		wait_pulse(gap);
		check_count(gap, 1, "clocks from reset release to first ce_pix");
		repeat (4) begin
			wait_pulse(gap);
			check_count(gap, gba_video_pkg::CE_DIV, "clocks between ce_pix pulses");
		end
	endtask

	task automatic line_timing();
		int   n;
		int   hs_n;
		int   hbl_n;
		logic prev_hs;
		next_pixel();
		run_until(HS_BIT, 1'b0, 2 * LINE_PIX, "hsync low", n);
		run_until(HS_BIT, 1'b1, 2 * LINE_PIX, "hsync rise", n);
		n     = 0;
		hs_n  = 0;
		hbl_n = 0;
		do begin
			prev_hs = cur_sync.hs;
			hs_n   += cur_sync.hs;
			hbl_n  += cur_sync.hbl;
			n++;
			next_pixel();
		end while (!(cur_sync.hs && !prev_hs) && n < 2 * LINE_PIX);
		check_count(n, LINE_PIX, "pixels between hsync rises");
		check_count(hs_n, gba_video_pkg::HS_WIDTH, "pixels with hsync high");
		check_count(hbl_n, LINE_PIX - gba_video_pkg::H_ACTIVE, "pixels with hblank high");
	endtask

	task automatic frame_alignment();
		logic        prev_vs;
		logic [31:0] rnd;
		int          n;
		// Park mid-line in vertical blank, hsync high
		n = 0;
		while (!(cur_sync.vbl && cur_sync.hs)) begin
			if (n >= 2 * LINE_PIX) report_timeout("no hsync pulse inside vertical blank");
			n++;
			next_pixel();
		end
		rnd = $urandom();
		write_word('0, rnd[14:0]);
		end_writes();

		// Raster restarts at 0,0 before the next tick; two pixels of pipeline follow
		n = 0;
		do begin
			prev_vs = cur_sync.vs;
			next_pixel();
			n++;
		end while (!(cur_sync.vs && !prev_vs) && n < 3 * LINE_PIX);
		if (!(cur_sync.vs && !prev_vs)) report_timeout("no vsync after frame start");
		check_count(n, LINE_PIX + gba_video_pkg::HS_START + 2, "pixels from frame start to vsync");

		run_until(VS_BIT, 1'b0, 8 * LINE_PIX, "vsync fall", n);
		check_count(n, 3 * LINE_PIX, "pixels with vsync high");
		run_until(VBL_BIT, 1'b0, gba_video_pkg::V_START * LINE_PIX, "vblank end", n);
		run_until(VBL_BIT, 1'b1, (gba_video_pkg::V_ACTIVE + 1) * LINE_PIX, "vblank start", n);
		check_count(n, gba_video_pkg::V_ACTIVE * LINE_PIX, "pixels with vblank low");
	endtask

	task automatic scan_order();
		int n;
		int seen;
		@(negedge clk_sys);
		desat = 2'd0;
		fill_frame();
		n    = 0;
		seen = 0;
		while (n < gba_video_pkg::FB_DEPTH) begin
			if (seen >= FRAME_PIX) report_timeout("frame ended before all words were shown");
			next_pixel();
			seen++;
			if (!cur_sync.hbl && !cur_sync.vbl) begin
				check_rgb(cur_rgb, model_colour(expected[n], 0), $sformatf("scan-out word %0d", n));
				n++;
			end
		end
	endtask

	task automatic desaturation_levels();
		int n;
		int seen;
		for (int lvl = 1; lvl <= 3; lvl++) begin
			run_until(VBL_BIT, 1'b1, FRAME_PIX, "vblank before refill", n);
			@(negedge clk_sys);
			desat = gba_video_pkg::desat_level_t'(lvl);
			fill_frame();
			n    = 0;
			seen = 0;
			while (n < 2 * gba_video_pkg::H_ACTIVE) begin  // First two visible lines
				if (seen >= FRAME_PIX) report_timeout("no visible pixels after refill");
				next_pixel();
				seen++;
				if (!cur_sync.hbl && !cur_sync.vbl) begin
					check_rgb(cur_rgb, model_colour(expected[n], lvl),
						$sformatf("level %0d word %0d", lvl, n));
					n++;
				end
			end
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		void'($urandom(52048));
		reset    = 1'b1;
		fb_wr    = '0;
		desat    = '0;
		cur_sync = '0;
		cur_rgb  = '0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;

		reset_and_rate();
		line_timing();
		frame_alignment();
		scan_order();
		desaturation_levels();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* compile.f */
hdl/gba_video_pkg.sv
hdl/frame_buffer.sv
hdl/video_timing.sv
hdl/desaturate_filter.sv
hdl/gba_video_out.sv
sim/tb_gba_video_out.sv

/* Bender.yml */
package:
  name: gba_video_out

sources:
  # Shared package
  - hdl/gba_video_pkg.sv
  # Display output RTL
  - files:
      - hdl/frame_buffer.sv
      - hdl/video_timing.sv
      - hdl/desaturate_filter.sv
      - hdl/gba_video_out.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_gba_video_out.sv
